//--- logic/cic_interp.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module cic_interp (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  logic                   strobe_i,
   input  logic [2:0]             log_rate_i,
   input  tx_sig_pkg::iq_sample_t sample_i,
   output tx_sig_pkg::iq_int_t    data_o
);

   localparam int N = `TX_CIC_N;
   localparam int W = `TX_INT_W + 3 * `TX_MAX_LOG_RATE;   // Room for rate^(N-1) growth
   localparam int FRAC_W = `TX_INT_W - `TX_SAMPLE_W;

   logic [2:0]          log_rate_c;
   logic [3:0]          shift;
   logic signed [W-1:0] x_in     [2];
   logic signed [W-1:0] stg_in   [2][N];   // Input of each comb stage
   logic signed [W-1:0] comb_out [2];
   logic signed [W-1:0] comb_dly [2][N];   // Previous input of each comb stage
   logic signed [W-1:0] comb_r   [2];
   logic                pulse_r;            // comb_r holds a fresh value
   logic signed [W-1:0] integ    [2][N];
   logic signed [W-1:0] shifted  [2];

   assign log_rate_c = (log_rate_i > 3'(`TX_MAX_LOG_RATE)) ?
                       3'(`TX_MAX_LOG_RATE) : log_rate_i;
   assign shift = {log_rate_c, 1'b0};   // Gain is rate squared

   // Sign extend and add the fractional zero bits
   assign x_in[0] = {{(W-`TX_INT_W){sample_i.i[`TX_SAMPLE_W-1]}}, sample_i.i, {FRAC_W{1'b0}}};
   assign x_in[1] = {{(W-`TX_INT_W){sample_i.q[`TX_SAMPLE_W-1]}}, sample_i.q, {FRAC_W{1'b0}}};

   always_comb begin
      logic signed [W-1:0] acc;
      for (int ch = 0; ch < 2; ch++) begin
         acc = x_in[ch];
         for (int k = 0; k < N; k++) begin
            stg_in[ch][k] = acc;
            acc = acc - comb_dly[ch][k];
         end
         comb_out[ch] = acc;
         shifted[ch] = integ[ch][N-1] >>> shift;   // Exact normalization for DC
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pulse_r <= 1'b0;
         data_o  <= '0;
         for (int ch = 0; ch < 2; ch++) begin
            comb_r[ch] <= '0;
            for (int k = 0; k < N; k++) begin
               comb_dly[ch][k] <= '0;
               integ[ch][k]    <= '0;
            end
         end
      end else if (run_i) begin
         pulse_r <= strobe_i;
         for (int ch = 0; ch < 2; ch++) begin
            // Combs at the sample rate
            if (strobe_i) begin
               comb_r[ch] <= comb_out[ch];
               for (int k = 0; k < N; k++) begin
                  comb_dly[ch][k] <= stg_in[ch][k];
               end
            end
            // Zero stuffed into the first integrator between strobes
            integ[ch][0] <= integ[ch][0] + (pulse_r ? comb_r[ch] : {W{1'b0}});
            for (int k = 1; k < N; k++) begin
               integ[ch][k] <= integ[ch][k] + integ[ch][k-1];
            end
         end
         data_o.i <= shifted[0][`TX_INT_W-1:0];
         data_o.q <= shifted[1][`TX_INT_W-1:0];
      end
   end

endmodule

//--- logic/dsp_core_tx.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module dsp_core_tx (
   input  logic                   clk,
   input  logic                   rst,
   input  tx_cfg_pkg::set_bus_t   set_i,
   input  logic                   run_i,
   input  tx_sig_pkg::iq_sample_t sample_i,
   output logic                   strobe_o,
   output tx_sig_pkg::dac_out_t   dac_o
);

   import tx_cfg_pkg::*;
   import tx_sig_pkg::*;

   tx_cfg_t     cfg;
   logic [31:0] interp_word;   // Only the low bits carry the rate
   iq_int_t     interp_data;

   setting_reg #(
      .ADDR(`TX_DSP_BASE + REG_PHASE_INC)
   ) sr_phase (
      .clk   (clk),
      .rst   (rst),
      .set_i (set_i),
      .data_o(cfg.phase_inc)
   );

   setting_reg #(
      .ADDR(`TX_DSP_BASE + REG_SCALE)
   ) sr_scale (
      .clk   (clk),
      .rst   (rst),
      .set_i (set_i),
      .data_o({cfg.scale_i, cfg.scale_q})   // I scale in the upper half
   );

   setting_reg #(
      .ADDR(`TX_DSP_BASE + REG_INTERP)
   ) sr_interp (
      .clk   (clk),
      .rst   (rst),
      .set_i (set_i),
      .data_o(interp_word)
   );

   assign cfg.log_rate = interp_word[2:0];

   // Sample request, also the CIC input strobe
   interp_strober strober (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .log_rate_i(cfg.log_rate),
      .strobe_o  (strobe_o)
   );

   cic_interp cic (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .strobe_i  (strobe_o),
      .log_rate_i(cfg.log_rate),
      .sample_i  (sample_i),
      .data_o    (interp_data)
   );

   tx_upconverter upconv (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run_i),
      .phase_inc_i(cfg.phase_inc),
      .scale_i_i  (cfg.scale_i),
      .scale_q_i  (cfg.scale_q),
      .data_i     (interp_data),
      .dac_o      (dac_o)
   );

endmodule

//--- logic/interp_strober.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module interp_strober (
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   input  logic [2:0] log_rate_i,
   output logic       strobe_o
);

   localparam int CNT_W = `TX_MAX_LOG_RATE;

   logic [2:0]       log_rate_c;
   logic [CNT_W-1:0] reload;
   logic [CNT_W-1:0] count;

   // Rates above the CIC limit run at the limit
   assign log_rate_c = (log_rate_i > 3'(`TX_MAX_LOG_RATE)) ?
                       3'(`TX_MAX_LOG_RATE) : log_rate_i;
   assign reload = CNT_W'((1 << log_rate_c) - 1);   // Clocks between strobes minus one

   always_ff @(posedge clk) begin
      if (rst) begin
         count    <= '0;
         strobe_o <= 1'b0;
      end else if (!run_i) begin
         count    <= '0;      // Next run starts with a strobe
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= (count == '0);
         if (count == '0) begin
            count <= reload;
         end else begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- logic/setting_reg.sv
`timescale 1ns/1ns

module setting_reg #(
   parameter int ADDR = 0
) (
   input  logic                 clk,
   input  logic                 rst,
   input  tx_cfg_pkg::set_bus_t set_i,
   output logic [31:0]          data_o
);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == 8'(ADDR));   // Write aimed at this register

   always_ff @(posedge clk) begin
      if (rst) begin
         data_o <= '0;
      end else if (hit) begin
         data_o <= set_i.data;
      end
   end

endmodule

//--- logic/tx_cfg_pkg.sv
package tx_cfg_pkg;

   // Register offsets from the settings base address
   typedef enum logic [7:0] {
      REG_PHASE_INC = 8'd0,   // NCO phase step per clock
      REG_SCALE     = 8'd1,   // {scale_i, scale_q}
      REG_INTERP    = 8'd2    // log2 of the interpolation rate in bits 2:0
   } tx_reg_e;

   // Configuration of the chain as held in the setting registers
   typedef struct packed {
      logic [31:0]        phase_inc;
      logic signed [15:0] scale_i;    // Q2.14, 0x4000 is unity
      logic signed [15:0] scale_q;    // Q2.14, 0x4000 is unity
      logic [2:0]         log_rate;   // Rates 1 to 16
   } tx_cfg_t;

   // One write cycle on the settings bus
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

endpackage

//--- logic/tx_dsp_defines.svh
`ifndef TX_DSP_DEFINES_SVH
`define TX_DSP_DEFINES_SVH

// Settings bus base address of the transmit chain
`define TX_DSP_BASE 128

// Data path widths
`define TX_SAMPLE_W 16
`define TX_INT_W 18

// CIC interpolator
`define TX_CIC_N 3
`define TX_MAX_LOG_RATE 4

// CORDIC rotator
`define TX_CORDIC_STAGES 16

`endif

//--- logic/tx_sig_pkg.sv
`include "tx_dsp_defines.svh"

package tx_sig_pkg;

   // Baseband input word, I in the upper half
   typedef struct packed {
      logic signed [`TX_SAMPLE_W-1:0] i;
      logic signed [`TX_SAMPLE_W-1:0] q;
   } iq_sample_t;

   // Internal I/Q pair with two fractional bits below the sample LSB
   typedef struct packed {
      logic signed [`TX_INT_W-1:0] i;
      logic signed [`TX_INT_W-1:0] q;
   } iq_int_t;

   // Words for the two DAC channels
   typedef struct packed {
      logic [15:0] dac_a;   // From I
      logic [15:0] dac_b;   // From Q
   } dac_out_t;

endpackage

//--- logic/tx_upconverter.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module tx_upconverter (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  logic [31:0]          phase_inc_i,
   input  logic signed [15:0]   scale_i_i,
   input  logic signed [15:0]   scale_q_i,
   input  tx_sig_pkg::iq_int_t  data_i,
   output tx_sig_pkg::dac_out_t dac_o
);

   localparam int S  = `TX_CORDIC_STAGES;
   localparam int CW = `TX_INT_W + 2;   // Headroom for negation and CORDIC growth
   localparam int GW = CW + 17;         // Gain product
   localparam int SW = CW + 16;         // Scale product

   localparam logic signed [16:0]   INV_GAIN = 17'sd19898;   // 1/1.64676 in Q1.15
   localparam logic signed [GW-1:0] G_RND = 1 <<< 14;
   localparam logic signed [SW-1:0] S_RND = 1 <<< 15;

   // atan(2^-k) with 65536 units per turn
   localparam logic signed [15:0] ATAN [S] = '{
      16'sd8192, 16'sd4836, 16'sd2555, 16'sd1297,
      16'sd651,  16'sd326,  16'sd163,  16'sd81,
      16'sd41,   16'sd20,   16'sd10,   16'sd5,
      16'sd3,    16'sd1,    16'sd1,    16'sd0
   };

   logic [31:0]          phase;
   logic                 flip;
   logic signed [CW-1:0] in_i;
   logic signed [CW-1:0] in_q;
   logic signed [CW-1:0] cx [S+1];
   logic signed [CW-1:0] cy [S+1];
   logic signed [15:0]   cz [S];
   logic signed [CW-1:0] gain_i;
   logic signed [CW-1:0] gain_q;

   // Removes the rotator growth
   function automatic logic signed [CW-1:0] gain_fix(input logic signed [CW-1:0] v);
      logic signed [GW-1:0] p;
      p = v * INV_GAIN;
      p = p + G_RND;
      return p[CW+14:15];
   endfunction

   // Q2.14 scale, drops the two fractional bits, rounds and saturates
   function automatic logic [15:0] scale_sat(input logic signed [CW-1:0] v,
                                             input logic signed [15:0]   s);
      logic signed [SW-1:0] p;
      logic signed [SW-17:0] q;
      p = v * s + S_RND;
      q = p[SW-1:16];
      if (q > 32767) begin
         return 16'h7fff;
      end else if (q < -32768) begin
         return 16'h8000;
      end
      return q[15:0];
   endfunction

   assign in_i = {{(CW-`TX_INT_W){data_i.i[`TX_INT_W-1]}}, data_i.i};
   assign in_q = {{(CW-`TX_INT_W){data_i.q[`TX_INT_W-1]}}, data_i.q};
   assign flip = phase[31] ^ phase[30];   // Phase in the left half plane

   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= '0;
      end else if (run_i) begin
         phase <= phase + phase_inc_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k <= S; k++) begin
            cx[k] <= '0;
            cy[k] <= '0;
         end
         for (int k = 0; k < S; k++) begin
            cz[k] <= '0;
         end
         gain_i <= '0;
         gain_q <= '0;
         dac_o  <= '0;
      end else begin
         // Rotate by 180 degrees so the CORDIC sees at most 90
         cx[0] <= flip ? -in_i : in_i;
         cy[0] <= flip ? -in_q : in_q;
         cz[0] <= flip ? (phase[31:16] ^ 16'h8000) : phase[31:16];
         for (int k = 0; k < S; k++) begin
            if (cz[k][15]) begin   // Negative residual, turn clockwise
               cx[k+1] <= cx[k] + (cy[k] >>> k);
               cy[k+1] <= cy[k] - (cx[k] >>> k);
            end else begin
               cx[k+1] <= cx[k] - (cy[k] >>> k);
               cy[k+1] <= cy[k] + (cx[k] >>> k);
            end
         end
         for (int k = 0; k < S - 1; k++) begin
            cz[k+1] <= cz[k][15] ? cz[k] + ATAN[k] : cz[k] - ATAN[k];
         end
         gain_i <= gain_fix(cx[S]);
         gain_q <= gain_fix(cy[S]);
         dac_o.dac_a <= scale_sat(gain_i, scale_i_i);
         dac_o.dac_b <= scale_sat(gain_q, scale_q_i);
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failures
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tx_dsp.f \
   --top-module tb_dsp_core_tx -o sim_tx_dsp || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tx_dsp > sim.log 2>&1 || echo "CHECKS FAILED (simulator exit status)" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

//--- testbench/dsp_core_tx_props.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module dsp_core_tx_props (
   input logic                 clk,
   input logic                 rst,
   input logic                 run_i,
   input logic                 strobe_i,
   input tx_cfg_pkg::tx_cfg_t  cfg_i,
   input tx_sig_pkg::dac_out_t dac_i
);

   logic [2:0] log_rate_c;
   logic [5:0] rate;
   logic [5:0] gap;     // Clocks since the last strobe, saturating
   logic       armed;   // A strobe was seen in this run

   assign log_rate_c = (cfg_i.log_rate > 3'(`TX_MAX_LOG_RATE)) ?
                       3'(`TX_MAX_LOG_RATE) : cfg_i.log_rate;
   assign rate = 6'd1 << log_rate_c;

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         armed <= 1'b0;
         gap   <= '0;
      end else if (strobe_i) begin
         armed <= 1'b1;
         gap   <= 6'd1;
      end else if (gap != 6'h3f) begin
         gap <= gap + 6'd1;
      end
   end

   a_idle_no_strobe: assert property (@(posedge clk) disable iff (rst) !run_i |=> !strobe_i)
      else $error("strobe_o high in the cycle after run_i was low");

   a_strobe_spacing: assert property (@(posedge clk) disable iff (rst)
      (strobe_i && armed) |-> (gap >= rate))
      else $error("strobe_o pulses closer than the interpolation rate");

   a_dac_reset: assert property (@(posedge clk) $fell(rst) |-> (dac_i == '0))
      else $error("dac_o not zero in the cycle after reset");

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #5 rst_o = 1'b0;   // Released with the other inputs
   end

endmodule

//--- testbench/tb_dsp_core_tx.sv
`timescale 1ns/1ns
`include "tx_dsp_defines.svh"

module tb_dsp_core_tx;

   import tx_cfg_pkg::*;
   import tx_sig_pkg::*;

   localparam int MAX_REC       = 32;
   localparam int REC_WORDS     = 13;
   localparam int SETTLE_CYCLES = 80;
   localparam int FLUSH_CYCLES  = 25;    // Upconverter pipeline drains
   localparam int HOLD_CYCLES   = 50;
   localparam int ZERO_CYCLES   = 100;   // Empties the CIC before the next rate

   logic        clk;
   logic        rst;
   set_bus_t    set_bus;
   logic        run;
   iq_sample_t  sample;
   logic        strobe;
   dac_out_t    dac;
   logic [31:0] vec_mem [0:MAX_REC*REC_WORDS];   // Word 0 is the record count
   logic [31:0] phase_inc_set;   // Phase step held by the DUT
   logic [31:0] phase_ref;       // NCO phase reached by the steps so far
   int          num_rec;
   int          cur_rec;
   int          checks;
   int          errors;

   tb_clock_gen clock_gen (.clk_o(clk), .rst_o(rst));

   dsp_core_tx UUT (
      .clk     (clk),
      .rst     (rst),
      .set_i   (set_bus),
      .run_i   (run),
      .sample_i(sample),
      .strobe_o(strobe),
      .dac_o   (dac)
   );

   bind dsp_core_tx dsp_core_tx_props props (
      .clk(clk), .rst(rst), .run_i(run_i), .strobe_i(strobe_o), .cfg_i(cfg), .dac_i(dac_o)
   );

   // Accumulator advances on every clock with run high
   always @(posedge clk) begin
      if (rst) begin
         phase_ref <= '0;
      end else if (run) begin
         phase_ref <= phase_ref + phase_inc_set;
      end
   end

   function automatic bit within_tol(input logic [15:0] a, input logic [15:0] b, input int tol);
      int diff;
      diff = int'($signed(a)) - int'($signed(b));
      return (diff <= tol) && (diff >= -tol);
   endfunction

   function automatic bit pair_match(input dac_out_t d, input logic [15:0] ea,
                                     input logic [15:0] eb, input int tol);
      return within_tol(d.dac_a, ea, tol) && within_tol(d.dac_b, eb, tol);
   endfunction

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected, input int tol);
      checks++;
      if (!within_tol(actual, expected, tol)) begin
         errors++;
         $display("FAILED %s (record %0d): actual 0x%h, expected 0x%h",
                  name, cur_rec, actual, expected);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #5;   // Outputs settled, inputs change here
   endtask

   task automatic write_setting(input tx_reg_e offset, input logic [31:0] value);
      set_bus.stb  = 1'b1;
      set_bus.addr = 8'(`TX_DSP_BASE + int'(offset));
      set_bus.data = value;
      next_cycle();
      if (offset == REG_PHASE_INC) begin
         phase_inc_set = value;
      end
      set_bus = '0;
   endtask

   task automatic check_reset_state();
      @(posedge clk);   // First clock with reset applied
      while (rst) begin
         @(negedge clk);
         check_value("dac_a", dac.dac_a, 16'h0000, 0);
         check_value("dac_b", dac.dac_b, 16'h0000, 0);
         check_value("strobe_o", 16'(strobe), 16'h0000, 0);
      end
      @(negedge clk);   // First cycle out of reset
      check_value("dac_a", dac.dac_a, 16'h0000, 0);
      check_value("dac_b", dac.dac_b, 16'h0000, 0);
      check_value("strobe_o", 16'(strobe), 16'h0000, 0);
      next_cycle();
   endtask

   task automatic check_strobe_rate(input int log_rate);
      int expected;
      int gap;
      int waited;
      expected = (log_rate > `TX_MAX_LOG_RATE) ? (1 << `TX_MAX_LOG_RATE) : (1 << log_rate);
      waited = 0;
      while (!strobe && waited < 64) begin
         next_cycle();
         waited++;
      end
      if (!strobe) begin
         errors++;
         $display("No sample strobe appeared after run_i was raised (record %0d)", cur_rec);
         return;
      end
      repeat (8) begin
         gap = 0;
         do begin
            next_cycle();
            gap++;
         end while (!strobe && gap < 64);
         check_value("strobe_o gap", 16'(gap), 16'(expected), 0);
      end
   endtask

   task automatic run_record(input int r);
      int          b;
      int          tol;
      int          k;
      bit          match;
      logic [15:0] exp_a [4];
      logic [15:0] exp_b [4];
      dac_out_t    held;
      b = 1 + r * REC_WORDS;
      cur_rec = r;
      tol = int'(vec_mem[b+4]);
      for (k = 0; k < 4; k++) begin
         exp_a[k] = vec_mem[b+5+2*k][15:0];
         exp_b[k] = vec_mem[b+6+2*k][15:0];
      end
      write_setting(REG_PHASE_INC, vec_mem[b]);
      write_setting(REG_SCALE, vec_mem[b+1]);
      write_setting(REG_INTERP, vec_mem[b+2]);
      sample = vec_mem[b+3];
      run = 1'b1;
      check_strobe_rate(int'(vec_mem[b+2]));
      repeat (SETTLE_CYCLES) next_cycle();
      k = 0;
      while (!pair_match(dac, exp_a[0], exp_b[0], tol) && k < 8) begin   // Find phase zero
         next_cycle();
         k++;
      end
      if (!pair_match(dac, exp_a[0], exp_b[0], tol)) begin
         errors++;
         $display("DAC output never reached the first expected pair in record %0d", r);
      end else begin
         for (k = 0; k < 4; k++) begin
            check_value("dac_a", dac.dac_a, exp_a[k], tol);
            check_value("dac_b", dac.dac_b, exp_b[k], tol);
            next_cycle();
         end
      end
      run = 1'b0;
      repeat (FLUSH_CYCLES) next_cycle();
      held = dac;
      match = 1'b0;
      for (k = 0; k < 4; k++) begin
         if (pair_match(held, exp_a[k], exp_b[k], tol)) begin
            match = 1'b1;
         end
      end
      if (!match) begin
         errors++;
         $display("DAC output held with run_i low matches no expected pair in record %0d", r);
      end
      repeat (HOLD_CYCLES) begin
         check_value("strobe_o", 16'(strobe), 16'h0000, 0);
         check_value("dac_a", dac.dac_a, held.dac_a, 0);
         check_value("dac_b", dac.dac_b, held.dac_b, 0);
         next_cycle();
      end
      sample = '0;
      run = 1'b1;
      repeat (ZERO_CYCLES) next_cycle();
      run = 1'b0;
      next_cycle();
      // One step back to phase zero for the next record
      write_setting(REG_PHASE_INC, -phase_ref);
      run = 1'b1;
      next_cycle();
      run = 1'b0;
      next_cycle();
   endtask

   initial begin : watchdog
      int timeout_cycles;
      #1;
      timeout_cycles = num_rec * 600 + 200;
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      set_bus       = '0;
      run           = 1'b0;
      sample        = '0;
      phase_inc_set = '0;
      checks        = 0;
      errors        = 0;
      cur_rec       = -1;
      $readmemh("testbench/tx_vectors.mem", vec_mem);
      num_rec = int'(vec_mem[0]);
      if (num_rec <= 0 || num_rec > MAX_REC) begin
         errors++;
         $display("Vector file is missing or holds an invalid record count");
         num_rec = 0;
      end
      check_reset_state();
      for (int r = 0; r < num_rec; r++) begin
         run_record(r);
      end
      $display("Summary: %0d records, %0d checks, %0d errors", num_rec, checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- testbench/tx_vectors.mem
// First word is the record count, then 13 hex words per record:
// phase_inc scale{i,q} log_rate sample{i,q} tol dac_a0 dac_b0 dac_a1 dac_b1 dac_a2 dac_b2 dac_a3 dac_b3
8
// DC passthrough at unity scale
00000000 40004000 0 1000e000 4 1000 e000 1000 e000 1000 e000 1000 e000
00000000 40004000 1 2710e890 4 2710 e890 2710 e890 2710 e890 2710 e890
// Quarter turn per clock
40000000 40004000 2 1f400bb8 4 1f40 0bb8 f448 1f40 e0c0 f448 0bb8 e0c0
40000000 40004000 3 d1201388 4 d120 1388 ec78 d120 2ee0 ec78 1388 2ee0
// Half and negated unity scale
00000000 20002000 4 3000c800 4 1800 e400 1800 e400 1800 e400 1800 e400
00000000 c000c000 2 20000800 4 e000 f800 e000 f800 e000 f800 e000 f800
// Full-scale samples with near double gain saturate
00000000 7fff7fff 1 7fff8000 0 7fff 8000 7fff 8000 7fff 8000 7fff 8000
40000000 7fff7fff 3 80007fff 0 8000 7fff 8000 8000 7fff 8000 7fff 7fff

//--- tx_dsp.f
+incdir+logic
logic/tx_cfg_pkg.sv
logic/tx_sig_pkg.sv
logic/setting_reg.sv
logic/interp_strober.sv
logic/cic_interp.sv
logic/tx_upconverter.sv
logic/dsp_core_tx.sv
testbench/tb_clock_gen.sv
testbench/dsp_core_tx_props.sv
testbench/tb_dsp_core_tx.sv
